//--- verilog/i2c_pkg.sv
`default_nettype none

package i2c_pkg;

    typedef logic [7:0] byte_t;

    // Fixed device type code carried in the top nibble of every control byte
    localparam logic [3:0] DEV_ID = 4'b1010;

    localparam logic RW_WRITE = 1'b0;
    localparam logic RW_READ  = 1'b1;

    // Level seen on the data line during the ninth bit
    localparam logic ACK  = 1'b0;
    localparam logic NACK = 1'b1;

    typedef enum logic [1:0] {
        CMD_START,
        CMD_STOP,
        CMD_WRITE,
        CMD_READ
    } bus_cmd_e;

endpackage

`default_nettype wire

//--- verilog/eeprom_pkg.sv
`default_nettype none

package eeprom_pkg;

    localparam int MEM_DEPTH = 2048;

    typedef logic [10:0] mem_addr_t;
    typedef logic [7:0]  mem_data_t;

    // S_ACK drives the ninth bit, then moves on to the state saved beside it
    typedef enum logic [2:0] {
        S_IDLE,
        S_CTRL,
        S_ADDR,
        S_WDATA,
        S_RDATA,
        S_ACK
    } slave_state_e;

endpackage

`default_nettype wire

//--- verilog/i2c_master_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_master_ctrl (
    input  wire                   sda,
    input  wire                   rst_n,
    input  wire                   start,
    input  wire                   rw,
    input  wire eeprom_pkg::mem_addr_t addr,
    input  wire eeprom_pkg::mem_data_t wdata,
    input  wire                   cmd_done,
    input  wire i2c_pkg::byte_t   rx_byte,
    output logic                  busy,
    output logic                  done,
    output eeprom_pkg::mem_data_t rdata,
    output i2c_pkg::bus_cmd_e     cmd,
    output i2c_pkg::byte_t        cmd_byte,
    output logic                  cmd_ack,
    output logic                  cmd_valid
);

    typedef enum logic [1:0] {
        M_IDLE,
        M_ISSUE,
        M_WAIT
    } ctrl_state_e;

    ctrl_state_e           state;
    logic [2:0]            step;
    logic [2:0]            last_step;
    logic                  rw_q;
    eeprom_pkg::mem_addr_t addr_q;
    eeprom_pkg::mem_data_t wdata_q;

    assign busy      = (state != M_IDLE);
    assign cmd_valid = (state == M_ISSUE);
    assign last_step = rw_q ? 3'd6 : 3'd4;

    // A random read fetches a single byte, so the master always answers with NACK
    assign cmd_ack = i2c_pkg::NACK;

    // Write: start, ctrl, addr, data, stop
    // Read: start, ctrl, addr, start, ctrl, read, stop
    always_comb
    begin
        cmd      = i2c_pkg::CMD_STOP;
        cmd_byte = '0;
        case (step)
            3'd0: cmd = i2c_pkg::CMD_START;
            3'd1:
            begin
                cmd      = i2c_pkg::CMD_WRITE;
                cmd_byte = {i2c_pkg::DEV_ID, addr_q[10:8], i2c_pkg::RW_WRITE};
            end
            3'd2:
            begin
                cmd      = i2c_pkg::CMD_WRITE;
                cmd_byte = addr_q[7:0];
            end
            3'd3:
            begin
                cmd      = rw_q ? i2c_pkg::CMD_START : i2c_pkg::CMD_WRITE;
                cmd_byte = wdata_q;
            end
            3'd4:
            begin
                cmd      = rw_q ? i2c_pkg::CMD_WRITE : i2c_pkg::CMD_STOP;
                cmd_byte = {i2c_pkg::DEV_ID, addr_q[10:8], i2c_pkg::RW_READ};
            end
            3'd5: cmd = i2c_pkg::CMD_READ;
            default: cmd = i2c_pkg::CMD_STOP;
        endcase
    end

    always_ff @(posedge sda or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state <= M_IDLE;
            step  <= '0;
            done  <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            case (state)
                M_IDLE:
                begin
                    if (start)
                    begin
                        step  <= '0;
                        state <= M_ISSUE;
                    end
                end
                M_ISSUE: state <= M_WAIT;
                default:
                begin
                    if (cmd_done)
                    begin
                        if (step == last_step)
                        begin
                            state <= M_IDLE;
                            done  <= 1'b1;
                        end
                        else
                        begin
                            step  <= step + 3'd1;
                            state <= M_ISSUE;
                        end
                    end
                end
            endcase
        end
    end

    always_ff @(posedge sda)
    begin
        if (state == M_IDLE && start)
        begin
            rw_q    <= rw;
            addr_q  <= addr;
            wdata_q <= wdata;
        end
        if (state == M_WAIT && cmd_done && step == 3'd5)
            rdata <= rx_byte;
    end

    // The engine takes one command at a time, so it only reports back while a command is out
    a_one_cmd_in_flight: assert property (@(posedge sda) disable iff (!rst_n)
        cmd_done |-> (state == M_WAIT));

endmodule

`default_nettype wire

//--- verilog/i2c_bit_engine.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_bit_engine #(
    parameter int CLK_DIV = 4
) (
    input  wire                     sda,
    input  wire                     rst_n,
    input  wire i2c_pkg::bus_cmd_e  cmd,
    input  wire i2c_pkg::byte_t     cmd_byte,
    input  wire                     cmd_ack,
    input  wire                     cmd_valid,
    input  wire                     ser_data,
    output logic                    cmd_done,
    output i2c_pkg::byte_t          rx_byte,
    output logic                    rx_ack,
    output logic                    scl,
    output logic                    master_pull
);

    localparam int QW = $clog2(CLK_DIV + 1);

    i2c_pkg::bus_cmd_e cmd_q;
    i2c_pkg::byte_t    shreg;
    logic              ack_q;
    logic              active;
    logic [QW-1:0]     qcnt;
    logic [1:0]        phase;
    logic [1:0]        nxt_phase;
    logic [3:0]        bit_cnt;
    logic [3:0]        nxt_bit;
    logic              q_end;
    logic              is_byte;
    logic              last_bit;

    // Line levels on entry to a quarter. Byte bits run scl low, high, high, low
    function automatic logic [1:0] drive(input i2c_pkg::bus_cmd_e c, input logic [1:0] p,
                                         input logic [3:0] b, input logic tx,
                                         input logic ack, input logic pull);
        logic s;
        logic d;
        s = (p == 2'd1) || (p == 2'd2);
        d = pull;
        case (c)
            i2c_pkg::CMD_START:
            begin
                if (p == 2'd0)
                    d = 1'b0;
                else if (p == 2'd2)
                    d = 1'b1;
            end
            i2c_pkg::CMD_STOP:
            begin
                s = (p != 2'd0);
                if (p == 2'd0)
                    d = 1'b1;
                else if (p == 2'd2)
                    d = 1'b0;
            end
            i2c_pkg::CMD_WRITE:
            begin
                if (p == 2'd0)
                    d = (b == 4'd8) ? 1'b0 : !tx;
            end
            default:
            begin
                if (p == 2'd0)
                    d = (b == 4'd8) ? (ack == i2c_pkg::ACK) : 1'b0;
            end
        endcase
        return {s, d};
    endfunction

    assign q_end     = active && (qcnt == QW'(CLK_DIV - 1));
    assign is_byte   = (cmd_q == i2c_pkg::CMD_WRITE) || (cmd_q == i2c_pkg::CMD_READ);
    assign last_bit  = !is_byte || (bit_cnt == 4'd8);
    assign nxt_phase = phase + 2'd1;
    assign nxt_bit   = (phase == 2'd3) ? bit_cnt + 4'd1 : bit_cnt;
    assign rx_byte   = shreg;

    always_ff @(posedge sda or negedge rst_n)
    begin
        if (!rst_n)
        begin
            active      <= 1'b0;
            cmd_q       <= i2c_pkg::CMD_STOP;
            qcnt        <= '0;
            phase       <= '0;
            bit_cnt     <= '0;
            cmd_done    <= 1'b0;
            scl         <= 1'b1;
            master_pull <= 1'b0;
        end
        else
        begin
            cmd_done <= 1'b0;
            if (!active)
            begin
                if (cmd_valid)
                begin
                    active  <= 1'b1;
                    cmd_q   <= cmd;
                    qcnt    <= '0;
                    phase   <= '0;
                    bit_cnt <= '0;
                    {scl, master_pull} <= drive(cmd, 2'd0, 4'd0, cmd_byte[7], cmd_ack,
                                                master_pull);
                end
            end
            else if (!q_end)
                qcnt <= qcnt + 1'b1;
            else
            begin
                qcnt <= '0;
                if (phase == 2'd3 && last_bit)
                begin
                    active   <= 1'b0;
                    cmd_done <= 1'b1;
                end
                else
                begin
                    phase   <= nxt_phase;
                    bit_cnt <= nxt_bit;
                    {scl, master_pull} <= drive(cmd_q, nxt_phase, nxt_bit, shreg[7], ack_q,
                                                master_pull);
                end
            end
        end
    end

    // Sample at the middle of the high half of scl
    always_ff @(posedge sda)
    begin
        if (cmd_valid && !active)
        begin
            shreg <= cmd_byte;
            ack_q <= cmd_ack;
        end
        else if (q_end && phase == 2'd1 && is_byte)
        begin
            if (bit_cnt == 4'd8)
                rx_ack <= ser_data;
            else
                shreg <= {shreg[6:0], ser_data};
        end
    end

    a_data_stable_high: assert property (@(posedge sda) disable iff (!rst_n)
        (scl && $past(scl) && master_pull != $past(master_pull))
            |-> (cmd_q == i2c_pkg::CMD_START || cmd_q == i2c_pkg::CMD_STOP));

endmodule

`default_nettype wire

//--- verilog/eeprom_slave.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_slave (
    input  wire  sda,
    input  wire  rst_n,
    input  wire  scl,
    input  wire  ser_data,
    output logic slave_pull
);

    eeprom_pkg::mem_data_t    mem [eeprom_pkg::MEM_DEPTH];
    eeprom_pkg::mem_data_t    rd_byte;
    eeprom_pkg::mem_data_t    wbuf;
    eeprom_pkg::mem_addr_t    addr;
    eeprom_pkg::slave_state_e state;
    eeprom_pkg::slave_state_e ack_next;
    i2c_pkg::byte_t           shreg;
    i2c_pkg::byte_t           tx;
    logic [3:0]               bit_cnt;
    logic                     write_pend;
    logic                     scl_meta;
    logic                     scl_q;
    logic                     scl_d;
    logic                     sd_meta;
    logic                     sd_q;
    logic                     sd_d;
    logic                     scl_rise;
    logic                     scl_fall;
    logic                     start_det;
    logic                     stop_det;
    logic                     byte_end;
    logic                     id_ok;
    logic                     rx_state;

    // Both lines idle high, so the synchronizer resets to one
    always_ff @(posedge sda or negedge rst_n)
    begin
        if (!rst_n)
        begin
            scl_meta <= 1'b1;
            scl_q    <= 1'b1;
            scl_d    <= 1'b1;
            sd_meta  <= 1'b1;
            sd_q     <= 1'b1;
            sd_d     <= 1'b1;
        end
        else
        begin
            scl_meta <= scl;
            scl_q    <= scl_meta;
            scl_d    <= scl_q;
            sd_meta  <= ser_data;
            sd_q     <= sd_meta;
            sd_d     <= sd_q;
        end
    end

    assign scl_rise  = scl_q && !scl_d;
    assign scl_fall  = !scl_q && scl_d;
    assign start_det = scl_q && scl_d && sd_d && !sd_q;
    assign stop_det  = scl_q && scl_d && !sd_d && sd_q;
    assign byte_end  = scl_fall && (bit_cnt == 4'd8);
    assign id_ok     = (shreg[7:4] == i2c_pkg::DEV_ID);
    assign rx_state  = (state == eeprom_pkg::S_CTRL) || (state == eeprom_pkg::S_ADDR) ||
                       (state == eeprom_pkg::S_WDATA);

    always_ff @(posedge sda or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state      <= eeprom_pkg::S_IDLE;
            ack_next   <= eeprom_pkg::S_IDLE;
            bit_cnt    <= '0;
            write_pend <= 1'b0;
            slave_pull <= 1'b0;
        end
        else if (start_det || stop_det)
        begin
            state      <= start_det ? eeprom_pkg::S_CTRL : eeprom_pkg::S_IDLE;
            bit_cnt    <= '0;
            write_pend <= 1'b0;
        end
        else if (rx_state)
        begin
            if (scl_rise)
                bit_cnt <= bit_cnt + 4'd1;
            else if (byte_end)
            begin
                bit_cnt <= '0;
                if (state == eeprom_pkg::S_CTRL && !id_ok)
                    state <= eeprom_pkg::S_IDLE;
                else
                begin
                    slave_pull <= 1'b1;
                    state      <= eeprom_pkg::S_ACK;
                    case (state)
                        eeprom_pkg::S_CTRL:
                            ack_next <= shreg[0] ? eeprom_pkg::S_RDATA : eeprom_pkg::S_ADDR;
                        eeprom_pkg::S_ADDR: ack_next <= eeprom_pkg::S_WDATA;
                        default:
                        begin
                            ack_next   <= eeprom_pkg::S_IDLE;
                            write_pend <= 1'b1;
                        end
                    endcase
                end
            end
        end
        else if (state == eeprom_pkg::S_ACK)
        begin
            if (scl_fall)
            begin
                state      <= ack_next;
                bit_cnt    <= '0;
                slave_pull <= (ack_next == eeprom_pkg::S_RDATA) ? !rd_byte[7] : 1'b0;
            end
        end
        else if (state == eeprom_pkg::S_RDATA)
        begin
            if (scl_rise)
                bit_cnt <= bit_cnt + 4'd1;
            else if (byte_end)
            begin
                // Master answers with NACK and a stop, so let the line go
                slave_pull <= 1'b0;
                state      <= eeprom_pkg::S_IDLE;
            end
            else if (scl_fall)
                slave_pull <= !tx[7];
        end
    end

    always_ff @(posedge sda)
    begin
        rd_byte <= mem[addr];
        if (scl_rise && rx_state)
            shreg <= {shreg[6:0], sd_q};
        if (byte_end && state == eeprom_pkg::S_CTRL && id_ok)
            addr[10:8] <= shreg[3:1];
        if (byte_end && state == eeprom_pkg::S_ADDR)
            addr[7:0] <= shreg;
        if (byte_end && state == eeprom_pkg::S_WDATA)
            wbuf <= shreg;
        if (scl_fall && state == eeprom_pkg::S_ACK)
            tx <= {rd_byte[6:0], 1'b0};
        else if (scl_fall && state == eeprom_pkg::S_RDATA)
            tx <= {tx[6:0], 1'b0};
        if (stop_det && write_pend)
            mem[addr] <= wbuf;
    end

    // The synchronizer delay must still leave the change inside the low half of the bus clock
    a_pull_scl_low: assert property (@(posedge sda) disable iff (!rst_n)
        (slave_pull != $past(slave_pull)) |-> !scl);

endmodule

`default_nettype wire

//--- verilog/eeprom_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_subsystem #(
    parameter int CLK_DIV = 4
) (
    input  wire                        sda,
    input  wire                        rst_n,
    input  wire                        start,
    input  wire                        rw,
    input  wire eeprom_pkg::mem_addr_t addr,
    input  wire eeprom_pkg::mem_data_t wdata,
    output logic                       busy,
    output logic                       done,
    output eeprom_pkg::mem_data_t      rdata,
    output logic                       scl,
    output logic                       ser_data
);

    i2c_pkg::bus_cmd_e cmd;
    i2c_pkg::byte_t    cmd_byte;
    i2c_pkg::byte_t    rx_byte;
    logic              cmd_ack;
    logic              cmd_valid;
    logic              cmd_done;
    logic              master_pull;
    logic              slave_pull;

    // Open-drain data line with a pull-up
    assign ser_data = !(master_pull || slave_pull);

    i2c_master_ctrl u_ctrl (
        .sda       (sda),
        .rst_n     (rst_n),
        .start     (start),
        .rw        (rw),
        .addr      (addr),
        .wdata     (wdata),
        .cmd_done  (cmd_done),
        .rx_byte   (rx_byte),
        .busy      (busy),
        .done      (done),
        .rdata     (rdata),
        .cmd       (cmd),
        .cmd_byte  (cmd_byte),
        .cmd_ack   (cmd_ack),
        .cmd_valid (cmd_valid)
    );

    i2c_bit_engine #(
        .CLK_DIV (CLK_DIV)
    ) u_engine (
        .sda         (sda),
        .rst_n       (rst_n),
        .cmd         (cmd),
        .cmd_byte    (cmd_byte),
        .cmd_ack     (cmd_ack),
        .cmd_valid   (cmd_valid),
        .ser_data    (ser_data),
        .cmd_done    (cmd_done),
        .rx_byte     (rx_byte),
        .rx_ack      (),
        .scl         (scl),
        .master_pull (master_pull)
    );

    eeprom_slave u_slave (
        .sda        (sda),
        .rst_n      (rst_n),
        .scl        (scl),
        .ser_data   (ser_data),
        .slave_pull (slave_pull)
    );

endmodule

`default_nettype wire

//--- testbench/tb_eeprom_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_eeprom_subsystem;

    localparam int     CLK_DIV     = 4;
    localparam int     SEED        = 50474;
    localparam int     OP_LIMIT    = 160 * 4 * CLK_DIV;
    localparam int     OPS_MAX     = 70;
    localparam longint WATCHDOG_NS = longint'(OPS_MAX) * 80 * 4 * CLK_DIV * 20 + 200_000;

    logic                  sda;
    logic                  rst_n;
    logic                  start;
    logic                  rw;
    eeprom_pkg::mem_addr_t addr;
    eeprom_pkg::mem_data_t wdata;
    logic                  busy;
    logic                  done;
    eeprom_pkg::mem_data_t rdata;
    logic                  scl;
    logic                  ser_data;

    eeprom_pkg::mem_data_t ref_mem [2048];
    bit                    written [2048];
    eeprom_pkg::mem_addr_t wr_list [$];
    logic                  exp_rw;
    eeprom_pkg::mem_data_t exp_data;
    logic                  scl_prev;
    logic                  sd_prev;
    int                    op_starts;
    int                    op_stops;
    int                    stops;
    int                    dones;
    int                    accepted;
    int                    ignored;
    int                    ops;
    int                    errors;
    int                    timeouts;

    eeprom_subsystem #(
        .CLK_DIV (CLK_DIV)
    ) u_dut (
        .sda      (sda),
        .rst_n    (rst_n),
        .start    (start),
        .rw       (rw),
        .addr     (addr),
        .wdata    (wdata),
        .busy     (busy),
        .done     (done),
        .rdata    (rdata),
        .scl      (scl),
        .ser_data (ser_data)
    );

    always #10 sda = ~sda;

    // Any data change while scl stays high is a bus condition: falling is start, rising is stop
    always @(posedge sda)
    begin
        if (rst_n)
        begin
            if (start && !busy)
            begin
                accepted++;
                op_starts = 0;
                op_stops  = 0;
            end
            if (start && busy)
                ignored++;
            if (scl && scl_prev && ser_data != sd_prev)
            begin
                if (ser_data)
                begin
                    op_stops++;
                    stops++;
                end
                else
                    op_starts++;
            end
            if (!busy)
                assert (scl && ser_data)
                else
                begin
                    errors++;
                    $display("error at %0t: bus lines not idle between operations", $time);
                end
            if (done)
            begin
                dones++;
                assert (!busy)
                else
                begin
                    errors++;
                    $display("error at %0t: busy still high with done", $time);
                end
                assert (op_starts == (exp_rw ? 2 : 1) && op_stops == 1)
                else
                begin
                    errors++;
                    $display("error at %0t: %0d starts and %0d stops in one operation",
                             $time, op_starts, op_stops);
                end
                if (exp_rw)
                    assert (rdata == exp_data)
                    else
                    begin
                        errors++;
                        $display("error at %0t: rdata %h, expected %h", $time, rdata, exp_data);
                    end
            end
        end
        scl_prev = scl;
        sd_prev  = ser_data;
    end

    // A nonzero poke_at pulses a conflicting start that many cycles into the operation
    task automatic run_op(input logic op_rw, input eeprom_pkg::mem_addr_t a,
                          input eeprom_pkg::mem_data_t d, input int poke_at);
        int cycles;
        cycles = 0;
        @(negedge sda);
        exp_rw   = op_rw;
        exp_data = op_rw ? ref_mem[a] : d;
        if (!op_rw)
        begin
            ref_mem[a] = d;
            if (!written[a])
            begin
                written[a] = 1'b1;
                wr_list.push_back(a);
            end
        end
        start = 1'b1;
        rw    = op_rw;
        addr  = a;
        wdata = d;
        @(negedge sda);
        start = 1'b0;
        while (!done && cycles < OP_LIMIT)
        begin
            if (poke_at > 0 && cycles == poke_at)
            begin
                start = 1'b1;
                rw    = !op_rw;
                addr  = ~a;
                wdata = ~d;
            end
            else
                start = 1'b0;
            cycles++;
            @(negedge sda);
        end
        start = 1'b0;
        ops++;
        if (!done)
        begin
            timeouts++;
            $display("operation at address %h did not finish within %0d cycles", a, OP_LIMIT);
        end
    endtask

    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the run did not complete", WATCHDOG_NS);
        $display("TESTS FAILED");
        $finish;
    end

    initial
    begin
        logic                  op_rw;
        eeprom_pkg::mem_addr_t a;
        void'($urandom(SEED));
        sda      = 1'b0;
        rst_n    = 1'b0;
        start    = 1'b0;
        rw       = 1'b0;
        addr     = '0;
        wdata    = '0;
        exp_rw   = 1'b0;
        exp_data = '0;
        scl_prev = 1'b1;
        sd_prev  = 1'b1;
        repeat (5) @(posedge sda);
        @(negedge sda);
        rst_n = 1'b1;
        @(negedge sda);
        assert (scl && ser_data && !busy && !done)
        else
        begin
            errors++;
            $display("error at %0t: outputs not idle after reset", $time);
        end

        run_op(1'b0, 11'h155, 8'ha7, 0);
        run_op(1'b1, 11'h155, 8'h00, 0);
        run_op(1'b0, 11'h6e2, 8'h3c, 0);
        run_op(1'b1, 11'h6e2, 8'h00, 0);

        // Same low byte in every block
        for (int blk = 0; blk < 8; blk++)
            run_op(1'b0, {3'(blk), 8'h3c}, 8'(blk * 37 + 11), 0);
        for (int blk = 0; blk < 8; blk++)
            run_op(1'b1, {3'(blk), 8'h3c}, 8'h00, 0);

        run_op(1'b0, 11'h2c0, 8'h5e, 40);
        run_op(1'b1, 11'h2c0, 8'h00, 100);

        for (int i = 0; i < 40; i++)
        begin
            op_rw = 1'($urandom);
            if (op_rw)
                a = wr_list[$urandom % wr_list.size()];
            else
                a = eeprom_pkg::mem_addr_t'($urandom);
            run_op(op_rw, a, 8'($urandom), 0);
        end

        repeat (8) @(negedge sda);
        assert (dones == accepted && accepted == ops && stops == dones && ignored == 2)
        else
        begin
            errors++;
            $display("error at %0t: %0d ops, %0d accepted, %0d done, %0d stops, %0d ignored",
                     $time, ops, accepted, dones, stops, ignored);
        end
        $display("summary: %0d operations, %0d errors, %0d timeouts", ops, errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
verilog/i2c_pkg.sv
verilog/eeprom_pkg.sv
verilog/i2c_master_ctrl.sv
verilog/i2c_bit_engine.sv
verilog/eeprom_slave.sv
verilog/eeprom_subsystem.sv
testbench/tb_eeprom_subsystem.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_eeprom_subsystem
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "TESTS PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
